/* source/rp_bus_pkg.sv */
// system bus definitions shared by the decoder and every register block
// one master, one outstanding access, ack one cycle after the strobe
// address is split into a region index and an offset inside the region;
// the region index sits right above the SYS_SW offset bits
// no byte enables, every write covers the whole register

package rp_bus_pkg;

  ////////////////////////////////////////////////////////////
  // widths and address split
  ////////////////////////////////////////////////////////////

  localparam int unsigned SYS_AW = 32;  // address width
  localparam int unsigned SYS_DW = 32;  // data width
  localparam int unsigned SYS_RN = 16;  // decoder regions
  localparam int unsigned SYS_SW = 18;  // offset bits per region

  ////////////////////////////////////////////////////////////
  // request and response
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [SYS_AW-1:0] addr;   // byte address
    logic [SYS_DW-1:0] wdata;  // write data
    logic              wen;    // write strobe, single cycle
    logic              ren;    // read strobe, single cycle
  } sys_req_t;

  typedef struct packed {
    logic [SYS_DW-1:0] rdata;  // valid with ack on reads
    logic              ack;    // one cycle after the strobe
    logic              err;    // bad region or bad offset
  } sys_rsp_t;

endpackage

/* source/rp_io_pkg.sv */
// analog IO definitions: ADC/DAC samples and PDM levels
// samples are 14-bit two's complement on both ADC and DAC side
// the two low ADC bits are reserved and get cleared in the frontend
// PDM levels are unsigned, a level of N gives N ones per 2^PDM_DWC clocks

package rp_io_pkg;

  ////////////////////////////////////////////////////////////
  // fast analog channels
  ////////////////////////////////////////////////////////////

  localparam int unsigned MNA = 2;  // ADC channels
  localparam int unsigned MNG = 2;  // DAC channels

  localparam int unsigned SMP_W = 14;  // sample width

  // shared by acquire and generate paths
  typedef logic signed [SMP_W-1:0] sample_t;

  ////////////////////////////////////////////////////////////
  // slow analog outputs (PDM)
  ////////////////////////////////////////////////////////////

  localparam int unsigned PDM_CHN = 4;  // outputs
  localparam int unsigned PDM_DWC = 8;  // level width

  typedef logic [PDM_DWC-1:0] pdm_lvl_t;  // unsigned level

endpackage

/* source/sys_bus_decoder.sv */
// system bus decoder, one master to RN regions
// region index is taken from the address bits right above SW offset bits
// forwarded addresses carry the offset only, region bits are cleared
// regions not set in MAP are answered here with ack and err, rdata zero
// expects one outstanding access at a time, checked below

`timescale 1ns/1ps

module sys_bus_decoder #(
  parameter int unsigned SW  = 18,      // offset bits
  parameter int unsigned RN  = 16,      // regions
  parameter logic [RN-1:0] MAP = '1     // mapped regions
)(
  input  logic                                adc_clk,
  input  logic                                top_rst,
  // master side
  input  rp_bus_pkg::sys_req_t                req_i,
  output rp_bus_pkg::sys_rsp_t                rsp_o,
  // region side
  output rp_bus_pkg::sys_req_t [RN-1:0]       req_o,
  input  rp_bus_pkg::sys_rsp_t [RN-1:0]       rsp_i
);

  localparam int unsigned IW = $clog2(RN);  // region index bits
  localparam int unsigned AW = rp_bus_pkg::SYS_AW;

  logic [IW-1:0] idx;     // region of current request
  logic          stb;     // any strobe
  logic          umap;    // strobe to unmapped region
  logic [IW-1:0] sel_q;   // region of pending response
  logic          pend_q;  // strobe seen last cycle
  logic          umap_q;  // local error answer due

  assign idx  = req_i.addr[SW +: IW];
  assign stb  = req_i.wen | req_i.ren;
  assign umap = stb & ~MAP[idx];

  // fan out, strobes go to a single mapped region
  always_comb begin
    for (int r = 0; r < RN; r++) begin
      req_o[r].addr  = {{(AW-SW){1'b0}}, req_i.addr[SW-1:0]};  // offset only
      req_o[r].wdata = req_i.wdata;
      req_o[r].wen   = req_i.wen & MAP[r] & (idx == IW'(r));
      req_o[r].ren   = req_i.ren & MAP[r] & (idx == IW'(r));
    end
  end

  // remember where the answer comes from
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sel_q  <= '0;
      pend_q <= 1'b0;
      umap_q <= 1'b0;
    end else begin
      pend_q <= stb;
      umap_q <= umap;
      if (stb) sel_q <= idx;  // hold between accesses
    end
  end

  // response mux
  always_comb begin
    if (umap_q) begin
      rsp_o.rdata = '0;     // nothing behind this region
      rsp_o.ack   = 1'b1;
      rsp_o.err   = 1'b1;
    end else if (pend_q) begin
      rsp_o = rsp_i[sel_q];
    end else begin
      rsp_o = '0;           // idle bus reads as zero
    end
  end

  ////////////////////////////////////////////////////////////
  // protocol checks
  ////////////////////////////////////////////////////////////

  a_one_strobe: assert property (@(posedge adc_clk) disable iff (top_rst)
    !(req_i.wen && req_i.ren))
    else $error("read and write strobe together");

  // ack comes back one cycle later, so back to back strobes mean no wait
  a_no_overlap: assert property (@(posedge adc_clk) disable iff (top_rst)
    stb |=> !stb)
    else $error("new strobe while response pending");

endmodule

/* source/mux_ctl_regs.sv */
// loopback multiplexer control, one register at offset 0
// bit i set routes DAC channel i back into ADC channel i
// any other offset answers err, reads there return zero

`timescale 1ns/1ps

module mux_ctl_regs (
  input  logic                         adc_clk,
  input  logic                         top_rst,
  // bus
  input  rp_bus_pkg::sys_req_t         req_i,
  output rp_bus_pkg::sys_rsp_t         rsp_o,
  // loopback select, one bit per ADC channel
  output logic [rp_io_pkg::MNA-1:0]    mux_loop_o
);

  localparam int unsigned MNA = rp_io_pkg::MNA;
  localparam int unsigned DW  = rp_bus_pkg::SYS_DW;

  logic hit;  // offset 0, low addr bits ignored

  assign hit = (req_i.addr[rp_bus_pkg::SYS_AW-1:2] == '0);

  ////////////////////////////////////////////////////////////
  // register and response
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      mux_loop_o <= '0;
      rsp_o      <= '0;
    end else begin
      rsp_o.ack <= req_i.wen | req_i.ren;         // always one cycle
      rsp_o.err <= (req_i.wen | req_i.ren) & ~hit;
      if (req_i.wen && hit) mux_loop_o <= req_i.wdata[MNA-1:0];
      // zero extended readback
      if (req_i.ren && hit) rsp_o.rdata <= {{(DW-MNA){1'b0}}, mux_loop_o};
      else                  rsp_o.rdata <= '0;
    end
  end

endmodule

/* source/reg_array.sv */
// bank of RN read/write registers, each of payload type RT
// register index is the byte offset divided by 4
// writes keep the low $bits(RT) bits of wdata
// reads sign extend a signed RT and zero extend an unsigned one
// index RN or above answers err, read data zero

`timescale 1ns/1ps

module reg_array #(
  parameter type         RT = logic [7:0],  // payload
  parameter int unsigned RN = 4             // registers
)(
  input  logic                  adc_clk,
  input  logic                  top_rst,
  // bus
  input  rp_bus_pkg::sys_req_t  req_i,
  output rp_bus_pkg::sys_rsp_t  rsp_o,
  // register values
  output RT [RN-1:0]            val_o
);

  localparam int unsigned DW = rp_bus_pkg::SYS_DW;
  localparam int unsigned AW = rp_bus_pkg::SYS_AW;
  localparam int unsigned IW = (RN > 1) ? $clog2(RN) : 1;
  localparam int unsigned VW = $bits(RT);

  logic [AW-3:0] idx;     // word index
  logic          hit;     // index inside the bank
  logic [IW-1:0] sel;     // bank select
  RT             rd_val;  // value under read

  assign idx    = req_i.addr[AW-1:2];
  assign hit    = (idx < RN);
  assign sel    = idx[IW-1:0];
  assign rd_val = val_o[sel];

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      val_o <= '0;
      rsp_o <= '0;
    end else begin
      rsp_o.ack <= req_i.wen | req_i.ren;
      rsp_o.err <= (req_i.wen | req_i.ren) & ~hit;  // past the last register
      if (req_i.wen && hit) val_o[sel] <= RT'(req_i.wdata[VW-1:0]);  // truncate
      // size cast keeps the sign of RT
      if (req_i.ren && hit) rsp_o.rdata <= DW'(rd_val);
      else                  rsp_o.rdata <= '0;
    end
  end

  // the master waits for ack, so acks never come back to back
  a_ack_single: assert property (@(posedge adc_clk) disable iff (top_rst)
    rsp_o.ack |=> !rsp_o.ack)
    else $error("ack high two cycles running");

endmodule

/* source/pdm_mod.sv */
// first order sigma-delta PDM, one output bit per channel
// each cycle the level is added to a DWC bit accumulator, the carry is the output
// with a constant level L there are exactly L ones in any 2^DWC cycle window
// a level of zero keeps the output low, full scale is 2^DWC-1 of 2^DWC

`timescale 1ns/1ps

module pdm_mod #(
  parameter int unsigned CHN = 4,  // channels
  parameter int unsigned DWC = 8   // level width
)(
  input  logic                     adc_clk,
  input  logic                     top_rst,
  // levels, unsigned
  input  logic [CHN-1:0][DWC-1:0]  lvl_i,
  // modulated outputs
  output logic [CHN-1:0]           pdm_o
);

  logic [CHN-1:0][DWC-1:0] acc_q;  // accumulators
  logic [CHN-1:0][DWC  :0] sum;    // carry in the top bit

  ////////////////////////////////////////////////////////////
  // accumulate
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < CHN; c++) begin
      sum[c] = {1'b0, acc_q[c]} + {1'b0, lvl_i[c]};
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      acc_q <= '0;
      pdm_o <= '0;   // outputs low in reset
    end else begin
      for (int c = 0; c < CHN; c++) begin
        acc_q[c] <= sum[c][DWC-1:0];  // wraps modulo 2^DWC
        pdm_o[c] <= sum[c][DWC];      // overflow is the pulse
      end
    end
  end

endmodule

/* source/adc_frontend.sv */
// ADC sample path, samples arrive parallel on adc_clk
// one register stage per channel, the two reserved low bits read as zero
// loopback bit set: the channel shows the DAC value, combinational, no delay
// the sample register behaves as an IO register and has no reset,
// so adc_sample_o is undefined for one cycle after power up

`timescale 1ns/1ps

module adc_frontend #(
  parameter int unsigned CHN = 2  // channels
)(
  input  logic                              adc_clk,
  // raw samples
  input  rp_io_pkg::sample_t [CHN-1:0]      adc_dat_i,
  // loopback select and source
  input  logic [CHN-1:0]                    loop_i,
  input  rp_io_pkg::sample_t [CHN-1:0]      dac_i,
  // samples toward acquisition
  output rp_io_pkg::sample_t [CHN-1:0]      sample_o
);

  localparam int unsigned SW = $bits(rp_io_pkg::sample_t);

  rp_io_pkg::sample_t [CHN-1:0] raw_q;  // registered samples

  ////////////////////////////////////////////////////////////
  // IO registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    for (int i = 0; i < CHN; i++) begin
      raw_q[i] <= {adc_dat_i[i][SW-1:2], 2'b00};  // reserved bits cleared
    end
  end

  // digital loopback
  always_comb begin
    for (int i = 0; i < CHN; i++) begin
      sample_o[i] = loop_i[i] ? dac_i[i] : raw_q[i];
    end
  end

endmodule

/* source/rp_top.sv */
// digital core of the board top, everything on adc_clk
// top_rst is asynchronous, active high, release should be synchronous to adc_clk
// bus regions: 1 loopback mux, 5 PDM levels, 7 DAC levels, others answer err
// DAC data comes straight from the level registers, no generator behind it
// dac_reset_o is held while top_rst is high and drops one edge after release

`timescale 1ns/1ps

module rp_top (
  input  logic                                   adc_clk,
  input  logic                                   top_rst,
  // system bus master port
  input  rp_bus_pkg::sys_req_t                   sys_req_i,
  output rp_bus_pkg::sys_rsp_t                   sys_rsp_o,
  // ADC
  input  rp_io_pkg::sample_t [rp_io_pkg::MNA-1:0] adc_dat_i,
  output rp_io_pkg::sample_t [rp_io_pkg::MNA-1:0] adc_sample_o,
  // DAC
  output rp_io_pkg::sample_t [rp_io_pkg::MNG-1:0] dac_dat_o,
  output logic                                   dac_reset_o,
  // PDM analog outputs
  output logic [rp_io_pkg::PDM_CHN-1:0]          dac_pwm_o
);

  ////////////////////////////////////////////////////////////
  // region numbering
  ////////////////////////////////////////////////////////////

  localparam int unsigned RN      = rp_bus_pkg::SYS_RN;
  localparam int unsigned REG_MUX = 1;  // loopback control
  localparam int unsigned REG_PDM = 5;  // PDM levels
  localparam int unsigned REG_DAC = 7;  // DAC levels

  localparam logic [RN-1:0] MAP = (RN'(1) << REG_MUX)
                                | (RN'(1) << REG_PDM)
                                | (RN'(1) << REG_DAC);

  rp_bus_pkg::sys_req_t [RN-1:0] sys_req;  // per region
  rp_bus_pkg::sys_rsp_t [RN-1:0] sys_rsp;

  logic [rp_io_pkg::MNA-1:0]                  mux_loop;  // digital loopback
  rp_io_pkg::pdm_lvl_t [rp_io_pkg::PDM_CHN-1:0] pdm_lvl;
  rp_io_pkg::sample_t  [rp_io_pkg::MNG-1:0]   dac_lvl;

  ////////////////////////////////////////////////////////////
  // bus decoder
  ////////////////////////////////////////////////////////////

  sys_bus_decoder #(
    .SW  (rp_bus_pkg::SYS_SW),
    .RN  (RN),
    .MAP (MAP)
  ) i_dec (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .req_i   (sys_req_i),
    .rsp_o   (sys_rsp_o),
    .req_o   (sys_req),
    .rsp_i   (sys_rsp)
  );

  // regions without a peer stay silent, the decoder answers them
  for (genvar r = 0; r < RN; r++) begin : g_idle
    if (!MAP[r]) begin : g_stub
      assign sys_rsp[r] = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // register blocks
  ////////////////////////////////////////////////////////////

  mux_ctl_regs i_mux (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .req_i      (sys_req[REG_MUX]),
    .rsp_o      (sys_rsp[REG_MUX]),
    .mux_loop_o (mux_loop)
  );

  reg_array #(
    .RT (rp_io_pkg::pdm_lvl_t),
    .RN (rp_io_pkg::PDM_CHN)
  ) i_pdm_regs (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .req_i   (sys_req[REG_PDM]),
    .rsp_o   (sys_rsp[REG_PDM]),
    .val_o   (pdm_lvl)
  );

  reg_array #(
    .RT (rp_io_pkg::sample_t),
    .RN (rp_io_pkg::MNG)
  ) i_dac_regs (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .req_i   (sys_req[REG_DAC]),
    .rsp_o   (sys_rsp[REG_DAC]),
    .val_o   (dac_lvl)
  );

  assign dac_dat_o = dac_lvl;  // changes with the write ack

  ////////////////////////////////////////////////////////////
  // analog paths
  ////////////////////////////////////////////////////////////

  pdm_mod #(
    .CHN (rp_io_pkg::PDM_CHN),
    .DWC (rp_io_pkg::PDM_DWC)
  ) i_pdm (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .lvl_i   (pdm_lvl),
    .pdm_o   (dac_pwm_o)
  );

  adc_frontend #(
    .CHN (rp_io_pkg::MNA)
  ) i_adc (
    .adc_clk   (adc_clk),
    .adc_dat_i (adc_dat_i),
    .loop_i    (mux_loop),
    .dac_i     (dac_lvl),     // loopback source, MNA == MNG
    .sample_o  (adc_sample_o)
  );

  // DAC reset, released one edge after top_rst
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) dac_reset_o <= 1'b1;
    else         dac_reset_o <= 1'b0;
  end

endmodule

/* verif/rp_top_tb.sv */
// testbench for rp_top, all stimulus on adc_clk, inputs change 1 ns after the edge
// a shadow model of the registers gives the expected bus and output values
// concurrent assertions compare bus responses and outputs on every adc_clk edge
// region numbers must match the ones used inside rp_top

`timescale 1ns/1ps

module rp_top_tb;

  localparam int unsigned TD      = 1;      // drive delay after the edge
  localparam int unsigned ACK_TMO = 16;     // cycles to wait for ack
  localparam int unsigned REG_MUX = 1;
  localparam int unsigned REG_PDM = 5;
  localparam int unsigned REG_DAC = 7;
  localparam int unsigned MNA     = rp_io_pkg::MNA;
  localparam int unsigned PDM_CHN = rp_io_pkg::PDM_CHN;
  localparam rp_io_pkg::sample_t LOW_CLR = 14'h3ffc;  // reserved bits masked

  logic                                  adc_clk;
  logic                                  top_rst;
  rp_bus_pkg::sys_req_t                  sys_req;
  rp_bus_pkg::sys_rsp_t                  sys_rsp;
  rp_io_pkg::sample_t [MNA-1:0]          adc_dat;
  rp_io_pkg::sample_t [MNA-1:0]          adc_sample_o;
  rp_io_pkg::sample_t [rp_io_pkg::MNG-1:0] dac_dat_o;
  logic                                  dac_reset_o;
  logic [PDM_CHN-1:0]                    dac_pwm_o;

  // shadow registers, updated once the write ack is seen
  logic [MNA-1:0]                          mux_mdl;
  rp_io_pkg::pdm_lvl_t [PDM_CHN-1:0]       pdm_mdl;
  rp_io_pkg::sample_t [rp_io_pkg::MNG-1:0] dac_mdl;
  logic [rp_bus_pkg::SYS_DW-1:0]           exp_rd;   // set along with the strobe
  logic                                    exp_err;
  int                                      err_cnt = 0;
  int                                      tmo_cnt = 0;

  rp_top i_dut (
    .adc_clk      (adc_clk),
    .top_rst      (top_rst),
    .sys_req_i    (sys_req),
    .sys_rsp_o    (sys_rsp),
    .adc_dat_i    (adc_dat),
    .adc_sample_o (adc_sample_o),
    .dac_dat_o    (dac_dat_o),
    .dac_reset_o  (dac_reset_o),
    .dac_pwm_o    (dac_pwm_o)
  );

  initial adc_clk = 1'b0;
  always #4 adc_clk = ~adc_clk;  // 8 ns

  // fresh random ADC word on every cycle
  always @(posedge adc_clk) begin
    #TD;
    for (int c = 0; c < MNA; c++) adc_dat[c] = rp_io_pkg::sample_t'($urandom);
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic log_mismatch(input string msg);
    err_cnt++;
    $display("CHECK FAILED @ %0t: %s", $time, msg);
  endtask

  task automatic finish_run();
    $display("errors: %0d failed checks, %0d timeouts", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  function automatic logic [31:0] reg_addr(input int unsigned region, input int unsigned idx);
    return (region << rp_bus_pkg::SYS_SW) | (idx << 2);
  endfunction

  // expected answer from the register map and the shadow values
  function automatic void expect_rsp(input logic [31:0] addr, output logic [31:0] rd,
                                     output logic er);
    int unsigned region;
    int unsigned idx;
    region = addr[rp_bus_pkg::SYS_SW +: 4];
    idx    = addr[rp_bus_pkg::SYS_SW-1:2];
    rd     = '0;
    er     = 1'b1;  // unmapped or past the last register
    if (region == REG_MUX && idx == 0) begin
      rd = {30'b0, mux_mdl};
      er = 1'b0;
    end else if (region == REG_PDM && idx < PDM_CHN) begin
      rd = {24'b0, pdm_mdl[idx]};
      er = 1'b0;
    end else if (region == REG_DAC && idx < rp_io_pkg::MNG) begin
      rd = {{18{dac_mdl[idx][13]}}, dac_mdl[idx]};  // sign extended
      er = 1'b0;
    end
  endfunction

  function automatic void update_model(input logic [31:0] addr, input logic [31:0] wdata);
    int unsigned region;
    int unsigned idx;
    region = addr[rp_bus_pkg::SYS_SW +: 4];
    idx    = addr[rp_bus_pkg::SYS_SW-1:2];
    if (region == REG_MUX)      mux_mdl      = wdata[MNA-1:0];
    else if (region == REG_PDM) pdm_mdl[idx] = wdata[7:0];
    else if (region == REG_DAC) dac_mdl[idx] = wdata[13:0];  // truncated
  endfunction

  // one strobe, then wait for ack
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic write);
    int          n;
    logic [31:0] rd;
    logic        er;
    expect_rsp(addr, rd, er);
    @(posedge adc_clk);
    #TD;
    exp_rd        = rd;
    exp_err       = er;
    sys_req.addr  = addr;
    sys_req.wdata = wdata;
    sys_req.wen   = write;
    sys_req.ren   = !write;
    @(posedge adc_clk);
    #TD;
    sys_req.wen = 1'b0;
    sys_req.ren = 1'b0;
    n = 0;
    while (!sys_rsp.ack && n < ACK_TMO) begin
      @(posedge adc_clk);
      #TD;
      n++;
    end
    if (sys_rsp.ack) begin
      if (write && !er) update_model(addr, wdata);
    end else begin
      $display("timeout: no ack for access to address %h", addr);
      tmo_cnt++;
      finish_run();
    end
  endtask

  task automatic read_all();
    int i;
    bus_access(reg_addr(REG_MUX, 0), '0, 1'b0);
    for (i = 0; i < PDM_CHN; i++) bus_access(reg_addr(REG_PDM, i), '0, 1'b0);
    for (i = 0; i < rp_io_pkg::MNG; i++) bus_access(reg_addr(REG_DAC, i), '0, 1'b0);
  endtask

  // count ones over one full accumulator period
  task automatic pdm_window();
    int cnt [PDM_CHN];
    int c;
    for (c = 0; c < PDM_CHN; c++) cnt[c] = 0;
    repeat (4) @(posedge adc_clk);  // let the new levels settle
    repeat (256) begin
      @(posedge adc_clk);
      #TD;
      for (c = 0; c < PDM_CHN; c++) if (dac_pwm_o[c]) cnt[c]++;
    end
    for (c = 0; c < PDM_CHN; c++) begin
      a_pdm_density: assert (cnt[c] == pdm_mdl[c])
        else log_mismatch($sformatf("pdm %0d: %0d ones, level %0d", c, cnt[c], pdm_mdl[c]));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  a_rst_hold: assert property (@(posedge adc_clk)
    top_rst |-> dac_reset_o && !sys_rsp.ack && !sys_rsp.err && dac_pwm_o == '0)
    else log_mismatch("outputs not in reset state");

  a_rst_release: assert property (@(posedge adc_clk)
    $fell(top_rst) |-> dac_reset_o && !sys_rsp.ack && dac_pwm_o == '0 ##1 !dac_reset_o)
    else log_mismatch("dac_reset_o not released one edge after reset");

  a_ack_lat: assert property (@(posedge adc_clk) disable iff (top_rst)
    (sys_req.wen || sys_req.ren) |=> sys_rsp.ack)
    else log_mismatch("no ack one cycle after strobe");

  a_ack_quiet: assert property (@(posedge adc_clk) disable iff (top_rst)
    !(sys_req.wen || sys_req.ren) |=> !sys_rsp.ack)
    else log_mismatch("ack without strobe");

  a_err: assert property (@(posedge adc_clk) disable iff (top_rst)
    (sys_req.wen || sys_req.ren) |=> sys_rsp.err == $past(exp_err))
    else log_mismatch("wrong err flag");

  a_rdata: assert property (@(posedge adc_clk) disable iff (top_rst)
    sys_req.ren |=> sys_rsp.rdata == $past(exp_rd))
    else log_mismatch($sformatf("read data %h", sys_rsp.rdata));

  a_dac_out: assert property (@(posedge adc_clk) disable iff (top_rst)
    dac_dat_o == dac_mdl)
    else log_mismatch("dac_dat_o differs from written level");

  for (genvar c = 0; c < MNA; c++) begin : g_adc
    a_adc_path: assert property (@(posedge adc_clk) disable iff (top_rst)
      !mux_mdl[c] |-> adc_sample_o[c] == ($past(adc_dat[c]) & LOW_CLR))
      else log_mismatch($sformatf("adc %0d sample %h", c, adc_sample_o[c]));
    a_loopback: assert property (@(posedge adc_clk) disable iff (top_rst)
      mux_mdl[c] |-> adc_sample_o[c] == dac_mdl[c])
      else log_mismatch($sformatf("adc %0d loopback %h", c, adc_sample_o[c]));
  end

  ////////////////////////////////////////////////////////////
  // sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h4e80));
    top_rst = 1'b0;
    sys_req = '0;
    adc_dat = '0;
    exp_rd  = '0;
    exp_err = 1'b0;
    mux_mdl = '0;
    pdm_mdl = '0;
    dac_mdl = '0;
    #TD top_rst = 1'b1;  // async reset edge ahead of the first clock
    repeat (16) @(posedge adc_clk);
    #TD top_rst = 1'b0;
    repeat (4) @(posedge adc_clk);
    read_all();  // reset values

    // random writes, readback through the model
    repeat (4) begin
      for (int i = 0; i < rp_io_pkg::MNG; i++) bus_access(reg_addr(REG_DAC, i), $urandom, 1'b1);
      for (int i = 0; i < PDM_CHN; i++) bus_access(reg_addr(REG_PDM, i), $urandom, 1'b1);
      bus_access(reg_addr(REG_MUX, 0), $urandom, 1'b1);
      read_all();
    end

    // unmapped regions and offsets past the last register
    bus_access(reg_addr(2, 0), '0, 1'b0);
    bus_access(reg_addr(2, 0), $urandom, 1'b1);
    bus_access(reg_addr(15, 3), '0, 1'b0);
    bus_access(reg_addr(REG_MUX, 1), '0, 1'b0);
    bus_access(reg_addr(REG_PDM, PDM_CHN), $urandom, 1'b1);
    bus_access(reg_addr(REG_DAC, rp_io_pkg::MNG), '0, 1'b0);

    // loopback one channel at a time, then both
    for (int m = 0; m < 4; m++) begin
      bus_access(reg_addr(REG_MUX, 0), m, 1'b1);
      repeat (8) @(posedge adc_clk);
      bus_access(reg_addr(REG_DAC, m % 2), $urandom, 1'b1);  // level moves under loopback
      repeat (8) @(posedge adc_clk);
    end
    bus_access(reg_addr(REG_MUX, 0), '0, 1'b1);  // loopback off again

    // PDM density, two sets of levels
    repeat (2) begin
      for (int i = 0; i < PDM_CHN; i++) bus_access(reg_addr(REG_PDM, i), $urandom, 1'b1);
      pdm_window();
    end

    repeat (4) @(posedge adc_clk);
    finish_run();
  end

endmodule

/* project.f */
source/rp_bus_pkg.sv
source/rp_io_pkg.sv
source/sys_bus_decoder.sv
source/mux_ctl_regs.sv
source/reg_array.sv
source/pdm_mod.sv
source/adc_frontend.sv
source/rp_top.sv
verif/rp_top_tb.sv

/* Bender.yml */
package:
  name: rp_core

sources:
  # packages first, modules refer to them by scoped names
  - source/rp_bus_pkg.sv
  - source/rp_io_pkg.sv
  - source/sys_bus_decoder.sv
  - source/mux_ctl_regs.sv
  - source/reg_array.sv
  - source/pdm_mod.sv
  - source/adc_frontend.sv
  - source/rp_top.sv
  - target: test
    files:
      - verif/rp_top_tb.sv
